/* all.f */
+incdir+include
design/mac_pkg.sv
design/fp_round_pack.sv
design/fp_mul_unit.sv
design/fp_add_unit.sv
design/mac_ctrl.sv
design/mac_top.sv
test/mac_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the MAC testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f all.f --top-module mac_tb \
    -Mdir obj_dir -o mac_sim &&
  ./obj_dir/mac_sim || exit 1

/* include/mac_ref.svh */
/* Reference model, LFSR helper and result check for the MAC testbench.
   Include inside the testbench module; the model rounds the product and the sum separately */
`ifndef MAC_REF_SVH
`define MAC_REF_SVH

function automatic bit nan_word(logic [31:0] w);
  return w[30:23] == 8'(mac_pkg::EXP_SPECIAL + mac_pkg::EXP_BIAS) && w[22:0] != 0;
endfunction

function automatic bit inf_word(logic [31:0] w);
  return w[30:23] == 8'(mac_pkg::EXP_SPECIAL + mac_pkg::EXP_BIAS) && w[22:0] == 0;
endfunction

function automatic bit zero_word(logic [31:0] w);
  return w[30:23] == 8'd0;
endfunction

// m is 24 mantissa bits followed by guard, round and sticky
function automatic logic [31:0] round_to_word(logic s, int e, logic [26:0] m);
  logic [24:0] r;
  r = {1'b0, m[26:3]} + 25'(m[2] & (m[1] | m[0] | m[3]));
  if (r[24]) begin
    r = r >> 1;
    e++;
  end
  if (e > mac_pkg::EXP_MAX) return {s, 8'hff, 23'd0};
  if (e < mac_pkg::EXP_MIN || !r[23]) return {s, 31'd0};
  return {s, 8'(e + mac_pkg::EXP_BIAS), r[22:0]};
endfunction

function automatic logic [31:0] mul_rounded(logic [31:0] a, logic [31:0] b);
  logic        s;
  int          e;
  logic [47:0] p;
  s = a[31] ^ b[31];
  if (nan_word(a) || nan_word(b)) return mac_pkg::QNAN_BITS;
  if ((inf_word(a) && zero_word(b)) || (inf_word(b) && zero_word(a))) begin
    return mac_pkg::QNAN_BITS;
  end
  if (inf_word(a) || inf_word(b)) return {s, 8'hff, 23'd0};
  if (zero_word(a) || zero_word(b)) return {s, 31'd0};
  p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
  e = int'(a[30:23]) + int'(b[30:23]) - 2 * mac_pkg::EXP_BIAS + 1;
  if (!p[47]) begin
    p = p << 1;
    e--;
  end
  return round_to_word(s, e, {p[47:22], |p[21:0]});
endfunction

function automatic logic [31:0] add_rounded(logic [31:0] x, logic [31:0] y, logic sub);
  logic        ys;
  logic        rs;
  int          xe;
  int          ye;
  logic [26:0] xm;
  logic [26:0] ym;
  logic [27:0] s;
  logic [26:0] m;
  ys = y[31] ^ sub;
  if (nan_word(x) || nan_word(y)) return mac_pkg::QNAN_BITS;
  if (inf_word(x) && inf_word(y) && x[31] != ys) return mac_pkg::QNAN_BITS;
  if (inf_word(x)) return x;
  if (inf_word(y)) return {ys, y[30:0]};
  if (zero_word(x) && zero_word(y)) return {x[31] & ys, 31'd0};
  if (zero_word(x)) return {ys, y[30:0]};
  if (zero_word(y)) return x;
  xe = int'(x[30:23]) - mac_pkg::EXP_BIAS;
  ye = int'(y[30:23]) - mac_pkg::EXP_BIAS;
  xm = {1'b1, x[22:0], 3'b000};
  ym = {1'b1, y[22:0], 3'b000};
  while (xe > ye) begin
    ym = {1'b0, ym[26:2], |ym[1:0]};
    ye++;
  end
  while (ye > xe) begin
    xm = {1'b0, xm[26:2], |xm[1:0]};
    xe++;
  end
  if (x[31] == ys) begin
    s  = xm + ym;
    rs = x[31];
  end else if (xm >= ym) begin
    s  = xm - ym;
    rs = x[31];
  end else begin
    s  = ym - xm;
    rs = ys;
  end
  if (s == 0) return 32'd0;
  m = s[26:0];
  if (s[27]) begin
    m = {s[27:2], |s[1:0]};
    xe++;
  end
  while (!m[26] && xe > mac_pkg::EXP_MIN) begin
    m = m << 1;
    xe--;
  end
  return round_to_word(rs, xe, m);
endfunction

function automatic mac_pkg::fp32_u mac_ref(mac_pkg::fp32_u a, mac_pkg::fp32_u b,
                                           mac_pkg::fp32_u c, logic op);
  mac_pkg::fp32_u res;
  res.bits = add_rounded(mul_rounded(a.bits, b.bits), c.bits, !op);
  return res;
endfunction

// Galois LFSR stepped once per returned bit
function automatic logic [31:0] lfsr_rand(inout logic [31:0] state, input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    r = {r[30:0], state[0]};
  end
  return r;
endfunction

task automatic check(string name, mac_pkg::fp32_u expected, mac_pkg::fp32_u actual);
  if (expected.bits !== actual.bits) begin
    $display("error %s: expected %h, actual %h", name, expected.bits, actual.bits);
    $display("Test FAILED");
    $fatal(1, "result mismatch in %s", name);
  end
endtask

`endif

/* test/mac_tb.sv */
/* Testbench for the MAC top level: directed, special and random operand sets checked
   against the reference model, with random back-pressure on the result */
module mac_tb;

  localparam int N_RANDOM   = 400;
  localparam int MAX_CYCLES = 460 * 80;

  logic           aclk;
  logic           rstn;
  mac_pkg::fp32_u a;
  mac_pkg::fp32_u b;
  mac_pkg::fp32_u c;
  mac_pkg::fp32_u ans;
  logic           op;
  logic           a_stb;
  logic           b_stb;
  logic           c_stb;
  logic           op_stb;
  logic           a_ack;
  logic           b_ack;
  logic           c_ack;
  logic           op_ack;
  logic           ans_stb;
  logic           ans_ack;

  logic [31:0]    lfsr_state;
  logic [31:0]    ack_lfsr;
  mac_pkg::fp32_u exp_q[$];
  string          name_q[$];
  int             sent;
  int             taken;
  int             accepted;
  int             cycles;
  logic           wait_prev;

  `include "mac_ref.svh"

  mac_top DUT (.*);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  task automatic protocol_error(string what);
    $display("Test FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic send(string name, mac_pkg::fp32_u av, mac_pkg::fp32_u bv,
                      mac_pkg::fp32_u cv, logic opv);
    @(posedge aclk);
    a      <= av;
    b      <= bv;
    c      <= cv;
    op     <= opv;
    a_stb  <= 1'b1;
    b_stb  <= 1'b1;
    c_stb  <= 1'b1;
    op_stb <= 1'b1;
    exp_q.push_back(mac_ref(av, bv, cv, opv));
    name_q.push_back(name);
    @(posedge aclk);
    while (!(a_ack && b_ack && c_ack && op_ack)) @(posedge aclk);
    a_stb  <= 1'b0;
    b_stb  <= 1'b0;
    c_stb  <= 1'b0;
    op_stb <= 1'b0;
    sent++;
  endtask

  function automatic mac_pkg::fp32_u rand_float(int lo, int span);
    mac_pkg::fp32_u v;
    v.f.sign = 1'(lfsr_rand(lfsr_state, 1));
    v.f.exp  = 8'(lo + int'(lfsr_rand(lfsr_state, 8)) % span);
    v.f.frac = 23'(lfsr_rand(lfsr_state, 23));
    return v;
  endfunction

  task automatic random_sets();
    mac_pkg::fp32_u ra;
    mac_pkg::fp32_u rb;
    mac_pkg::fp32_u rc;
    mac_pkg::fp32_u prod;
    logic [1:0]     mode;
    logic           rop;
    for (int i = 0; i < N_RANDOM; i++) begin
      mode = 2'(lfsr_rand(lfsr_state, 2));
      rop  = 1'(lfsr_rand(lfsr_state, 1));
      ra   = rand_float(120, 16);
      rb   = rand_float(120, 16);
      rc   = rand_float(118, 20);
      case (mode)
        // c nearly equal to the product with opposite effective sign
        2'd1: begin
          prod.bits = mul_rounded(ra.bits, rb.bits);
          rc.bits   = {prod.bits[31] ^ rop, prod.bits[30:6], 6'(lfsr_rand(lfsr_state, 6))};
        end
        2'd2: begin
          ra = rand_float(1, 254);
          rb = rand_float(1, 254);
          rc = rand_float(1, 254);
        end
        // Short mantissas put c on the guard bits
        2'd3: begin
          ra.f.frac = {ra.f.frac[22:12], 12'd0};
          rb.f.frac = {rb.f.frac[22:12], 12'd0};
          rc.f.exp  = 8'(int'(ra.f.exp) + int'(rb.f.exp) - 151
                         - int'(lfsr_rand(lfsr_state, 2)));
        end
        default: ;
      endcase
      send($sformatf("random %0d", i), ra, rb, rc, rop);
    end
  endtask

  initial begin
    ack_lfsr = 32'hf674dc49;
    forever begin
      @(posedge aclk);
      ans_ack <= rstn && (lfsr_rand(ack_lfsr, 2) != 0);
    end
  end

  // Compare presented results and watch the handshakes
  initial begin
    forever begin
      @(posedge aclk);
      if (rstn) begin
        if (wait_prev && !ans_stb) begin
          protocol_error("ans_stb dropped before the result was accepted");
        end
        if (ans_stb && (a_ack || b_ack || c_ack || op_ack)) begin
          protocol_error("input ack high while a result is waiting");
        end
        if (a_ack && b_ack && c_ack && op_ack && a_stb && b_stb && c_stb && op_stb) begin
          if (taken != accepted) begin
            protocol_error("operands taken before the result was accepted");
          end
          taken++;
        end
        // Every cycle of a held result must show the expected word
        if (ans_stb) begin
          if (exp_q.size() == 0) protocol_error("result presented without operands");
          check(name_q[0], exp_q[0], ans);
          if (ans_ack) begin
            exp_q.delete(0);
            name_q.delete(0);
            accepted++;
          end
        end
        wait_prev = ans_stb && !ans_ack;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge aclk);
      cycles++;
    end
    $display("Test FAILED");
    $fatal(1, "run did not finish within %0d cycles", MAX_CYCLES);
  end

  initial begin
    lfsr_state = 32'hf674dc49;
    rstn       = 1'b0;
    a          = '0;
    b          = '0;
    c          = '0;
    op         = 1'b0;
    a_stb      = 1'b0;
    b_stb      = 1'b0;
    c_stb      = 1'b0;
    op_stb     = 1'b0;
    ans_ack    = 1'b0;
    sent       = 0;
    taken      = 0;
    accepted   = 0;
    wait_prev  = 1'b0;
    repeat (2) @(posedge aclk);
    if (ans_stb || a_ack || b_ack || c_ack || op_ack) protocol_error("outputs high after reset");
    rstn <= 1'b1;

    send("1.5*2+0.25", 32'h3fc00000, 32'h40000000, 32'h3e800000, 1'b1);
    send("3*3-10", 32'h40400000, 32'h40400000, 32'h41200000, 1'b0);
    send("3*3+10", 32'h40400000, 32'h40400000, 32'h41200000, 1'b1);
    send("carry", 32'h3fffffff, 32'h3f800000, 32'h3fffffff, 1'b1);
    send("x*1-x", 32'h40490fdb, 32'h3f800000, 32'h40490fdb, 1'b0);
    send("nan a", 32'h7fc00000, 32'h3f800000, 32'h3f800000, 1'b1);
    send("nan b", 32'h3f800000, 32'h7f800001, 32'h3f800000, 1'b1);
    send("nan c", 32'h3f800000, 32'h3f800000, 32'hffc00000, 1'b0);
    send("inf*0", 32'h7f800000, 32'h00000000, 32'h3f800000, 1'b1);
    send("inf-inf", 32'h7f800000, 32'h3f800000, 32'h7f800000, 1'b0);
    send("-inf*2+1", 32'hff800000, 32'h40000000, 32'h3f800000, 1'b1);
    send("1+(-inf)", 32'h3f800000, 32'h3f800000, 32'hff800000, 1'b1);
    send("1-(-inf)", 32'h3f800000, 32'h3f800000, 32'hff800000, 1'b0);
    send("-0*1+-0", 32'h80000000, 32'h3f800000, 32'h80000000, 1'b1);
    send("0*1-0", 32'h00000000, 32'h3f800000, 32'h00000000, 1'b0);
    send("0*2+3", 32'h00000000, 32'h40000000, 32'h40400000, 1'b1);
    send("2*2+0", 32'h40000000, 32'h40000000, 32'h80000000, 1'b1);
    send("exp field 0", 32'h00400000, 32'h40000000, 32'h3f800000, 1'b1);
    send("tiny flush", 32'h00800000, 32'hbf000000, 32'h00000000, 1'b1);
    send("huge", 32'h7f000000, 32'h7f000000, 32'h3f800000, 1'b1);
    send("-huge", 32'hff000000, 32'h7f000000, 32'h3f800000, 1'b0);
    random_sets();

    while (accepted < sent) @(posedge aclk);
    $display("Test OK");
    $finish;
  end

endmodule

/* design/mac_top.sv */
/* Single-precision multiply-accumulate, ans = a*b + c for op 1 and a*b - c for op 0.
   Each input and the result use their own stb/ack transfer */
module mac_top (
  input  logic           aclk,
  input  logic           rstn,
  input  mac_pkg::fp32_u a,
  input  logic           a_stb,
  output logic           a_ack,
  input  mac_pkg::fp32_u b,
  input  logic           b_stb,
  output logic           b_ack,
  input  mac_pkg::fp32_u c,
  input  logic           c_stb,
  output logic           c_ack,
  input  logic           op,
  input  logic           op_stb,
  output logic           op_ack,
  output mac_pkg::fp32_u ans,
  output logic           ans_stb,
  input  logic           ans_ack
);

  logic                mul_start;
  logic                mul_done;
  logic                add_start;
  logic                add_done;
  logic                sub_op;
  mac_pkg::fp32_u      op_a;
  mac_pkg::fp32_u      op_b;
  mac_pkg::fp32_u      op_c;
  mac_pkg::fp32_u      ab;
  mac_pkg::fp32_u      sum;
  mac_pkg::unrounded_t mul_unr;
  logic                mul_is_special;
  mac_pkg::fp32_u      mul_special;
  mac_pkg::fp32_u      mul_packed;
  mac_pkg::unrounded_t add_unr;
  logic                add_is_special;
  mac_pkg::fp32_u      add_special;
  mac_pkg::fp32_u      add_packed;

  mac_ctrl u_ctrl (
    .aclk, .rstn,
    .a, .a_stb, .a_ack, .b, .b_stb, .b_ack,
    .c, .c_stb, .c_ack, .op, .op_stb, .op_ack,
    .ans, .ans_stb, .ans_ack,
    .mul_start, .mul_done, .add_start, .add_done,
    .ab, .sum, .op_a, .op_b, .op_c, .sub_op
  );

  fp_mul_unit u_mul (
    .aclk, .rstn, .start(mul_start), .op_a, .op_b,
    .packed_word(mul_packed), .unrounded(mul_unr), .is_special(mul_is_special),
    .special(mul_special), .done(mul_done), .ab
  );

  fp_round_pack u_mul_round (
    .value(mul_unr), .is_special(mul_is_special), .special(mul_special),
    .packed_word(mul_packed)
  );

  fp_add_unit u_add (
    .aclk, .rstn, .start(add_start), .op_ab(ab), .op_c, .sub_op,
    .packed_word(add_packed), .unrounded(add_unr), .is_special(add_is_special),
    .special(add_special), .done(add_done), .sum
  );

  fp_round_pack u_add_round (
    .value(add_unr), .is_special(add_is_special), .special(add_special),
    .packed_word(add_packed)
  );

endmodule

/* design/mac_ctrl.sv */
/* Sequencer of the MAC: takes an operand set over stb/ack, runs the multiply and add units
   in turn and holds the result with ans_stb until ans_ack */
module mac_ctrl (
  input  logic           aclk,
  input  logic           rstn,
  input  mac_pkg::fp32_u a,
  input  logic           a_stb,
  output logic           a_ack,
  input  mac_pkg::fp32_u b,
  input  logic           b_stb,
  output logic           b_ack,
  input  mac_pkg::fp32_u c,
  input  logic           c_stb,
  output logic           c_ack,
  input  logic           op,
  input  logic           op_stb,
  output logic           op_ack,
  output mac_pkg::fp32_u ans,
  output logic           ans_stb,
  input  logic           ans_ack,
  output logic           mul_start,
  input  logic           mul_done,
  output logic           add_start,
  input  logic           add_done,
  input  mac_pkg::fp32_u ab,
  input  mac_pkg::fp32_u sum,
  output mac_pkg::fp32_u op_a,
  output mac_pkg::fp32_u op_b,
  output mac_pkg::fp32_u op_c,
  output logic           sub_op
);

  typedef enum logic [1:0] {C_IDLE, C_MUL, C_ADD, C_PRESENT} ctrl_state_t;

  ctrl_state_t state;
  logic        ack_q;
  logic        take;

  assign take   = ack_q & a_stb & b_stb & c_stb & op_stb;
  assign a_ack  = ack_q;
  assign b_ack  = ack_q;
  assign c_ack  = ack_q;
  assign op_ack = ack_q;

  always_ff @(posedge aclk) begin
    if (!rstn) begin
      state     <= C_IDLE;
      ack_q     <= 1'b0;
      mul_start <= 1'b0;
      add_start <= 1'b0;
      ans_stb   <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      add_start <= 1'b0;
      case (state)
        C_IDLE: begin
          ack_q <= !take;
          if (take) begin
            mul_start <= 1'b1;
            state     <= C_MUL;
          end
        end
        C_MUL: if (mul_done) begin
          add_start <= 1'b1;
          state     <= C_ADD;
        end
        C_ADD: if (add_done) begin
          ans_stb <= 1'b1;
          state   <= C_PRESENT;
        end
        default: if (ans_ack) begin
          ans_stb <= 1'b0;
          state   <= C_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      op_a   <= a;
      op_b   <= b;
      op_c   <= c;
      sub_op <= !op;
    end
    if (state == C_ADD && add_done) ans <= sum;
  end

  ack_only_idle: assert property (@(posedge aclk) disable iff (!rstn)
    ack_q |-> (state == C_IDLE && !ans_stb));

  ans_held: assert property (@(posedge aclk) disable iff (!rstn)
    (ans_stb && !ans_ack) |=> (ans_stb && $stable(ans)));

  // Multiplier must hold its product through the add phase
  ab_held: assert property (@(posedge aclk) disable iff (!rstn)
    state == C_ADD |-> $stable(ab));

endmodule

/* design/fp_add_unit.sv */
/* Adder stage of the MAC: forms ab + c or ab - c with serial alignment and normalisation.
   Pulse start with stable operands; done pulses with the rounded result on sum */
module fp_add_unit (
  input  logic                aclk,
  input  logic                rstn,
  input  logic                start,
  input  mac_pkg::fp32_u      op_ab,
  input  mac_pkg::fp32_u      op_c,
  input  logic                sub_op,
  input  mac_pkg::fp32_u      packed_word,
  output mac_pkg::unrounded_t unrounded,
  output logic                is_special,
  output mac_pkg::fp32_u      special,
  output logic                done,
  output mac_pkg::fp32_u      sum
);

  typedef enum logic [2:0] {A_IDLE, A_ALIGN, A_ADD, A_CARRY, A_NORM} add_state_t;

  add_state_t        state;
  logic              c_sign;
  logic              x_nan;
  logic              x_inf;
  logic              x_zero;
  logic              y_nan;
  logic              y_inf;
  logic              y_zero;
  logic              norm_stop;
  logic              finish;
  logic              x_s;
  logic              y_s;
  logic signed [9:0] x_e;
  logic signed [9:0] y_e;
  logic [26:0]       x_m;
  logic [26:0]       y_m;
  logic [27:0]       acc;
  logic              res_s;
  logic signed [9:0] res_e;
  logic [26:0]       res_m;

  always_comb begin
    c_sign = op_c.f.sign ^ sub_op;
    x_nan  = (&op_ab.f.exp) & (|op_ab.f.frac);
    x_inf  = (&op_ab.f.exp) & ~(|op_ab.f.frac);
    x_zero = ~(|op_ab.f.exp);
    y_nan  = (&op_c.f.exp) & (|op_c.f.frac);
    y_inf  = (&op_c.f.exp) & ~(|op_c.f.frac);
    y_zero = ~(|op_c.f.exp);

    is_special = 1'b1;
    special    = op_ab;
    if (x_nan | y_nan) begin
      special.bits = mac_pkg::QNAN_BITS;
    end else if (x_inf & y_inf & (op_ab.f.sign != c_sign)) begin
      special.bits = mac_pkg::QNAN_BITS;
    end else if (x_inf) begin
      special = op_ab;
    end else if (y_inf) begin
      special.bits = {c_sign, op_c.bits[30:0]};
    end else if (x_zero & y_zero) begin
      special.bits = {op_ab.f.sign & c_sign, 31'd0};
    end else if (x_zero) begin
      special.bits = {c_sign, op_c.bits[30:0]};
    end else if (!y_zero) begin
      is_special = 1'b0;
    end
  end

  // Low three bits of res_m are guard, round and sticky
  assign unrounded = '{sign: res_s, exp: res_e, mant: res_m[26:3],
                       guard: res_m[2], round_bit: res_m[1], sticky: res_m[0]};

  assign norm_stop = res_m[26] || res_m == '0 || res_e <= mac_pkg::EXP_MIN;
  assign finish    = (state == A_IDLE && start && is_special) ||
                     (state == A_NORM && norm_stop);

  always_ff @(posedge aclk) begin
    if (!rstn) begin
      state <= A_IDLE;
      done  <= 1'b0;
    end else begin
      done <= finish;
      case (state)
        A_IDLE:  if (start && !is_special) state <= A_ALIGN;
        A_ALIGN: if (x_e == y_e) state <= A_ADD;
        A_ADD:   state <= A_CARRY;
        A_CARRY: state <= A_NORM;
        default: if (norm_stop) state <= A_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    case (state)
      A_IDLE: if (start) begin
        x_s <= op_ab.f.sign;
        x_e <= 10'(int'(op_ab.f.exp) - mac_pkg::EXP_BIAS);
        x_m <= {1'b1, op_ab.f.frac, 3'b000};
        y_s <= c_sign;
        y_e <= 10'(int'(op_c.f.exp) - mac_pkg::EXP_BIAS);
        y_m <= {1'b1, op_c.f.frac, 3'b000};
      end
      // Smaller operand moves right, lost bits collect in bit 0
      A_ALIGN: if (x_e > y_e) begin
        y_m <= {1'b0, y_m[26:2], |y_m[1:0]};
        y_e <= y_e + 10'sd1;
      end else if (y_e > x_e) begin
        x_m <= {1'b0, x_m[26:2], |x_m[1:0]};
        x_e <= x_e + 10'sd1;
      end
      A_ADD: begin
        res_e <= x_e;
        if (x_s == y_s) begin
          acc   <= x_m + y_m;
          res_s <= x_s;
        end else if (x_m >= y_m) begin
          acc   <= x_m - y_m;
          res_s <= x_s;
        end else begin
          acc   <= y_m - x_m;
          res_s <= y_s;
        end
      end
      A_CARRY: begin
        if (acc[27]) begin
          res_m <= {acc[27:2], |acc[1:0]};
          res_e <= res_e + 10'sd1;
        end else begin
          res_m <= acc[26:0];
        end
        // Exact cancellation is +0
        if (acc == '0) res_s <= 1'b0;
      end
      default: if (!norm_stop) begin
        res_m <= res_m << 1;
        res_e <= res_e - 10'sd1;
      end
    endcase
    if (finish) sum <= packed_word;
  end

endmodule

/* design/fp_mul_unit.sv */
/* Multiplier stage of the MAC: special cases, 24x24 mantissa product and one-step normalise.
   Pulse start with stable operands; done pulses with the rounded product on ab */
module fp_mul_unit (
  input  logic                aclk,
  input  logic                rstn,
  input  logic                start,
  input  mac_pkg::fp32_u      op_a,
  input  mac_pkg::fp32_u      op_b,
  input  mac_pkg::fp32_u      packed_word,
  output mac_pkg::unrounded_t unrounded,
  output logic                is_special,
  output mac_pkg::fp32_u      special,
  output logic                done,
  output mac_pkg::fp32_u      ab
);

  typedef enum logic [1:0] {M_IDLE, M_TAKE, M_NORM} mul_state_t;

  mul_state_t        state;
  logic              finish;
  logic              a_nan;
  logic              a_inf;
  logic              a_zero;
  logic              b_nan;
  logic              b_inf;
  logic              b_zero;
  logic              sign_x;
  logic              prod_sign;
  logic signed [9:0] prod_exp;
  logic [47:0]       product;
  logic [23:0]       mant;
  logic              guard;
  logic              round_bit;
  logic              sticky;

  always_comb begin
    a_nan  = (&op_a.f.exp) & (|op_a.f.frac);
    a_inf  = (&op_a.f.exp) & ~(|op_a.f.frac);
    a_zero = ~(|op_a.f.exp);
    b_nan  = (&op_b.f.exp) & (|op_b.f.frac);
    b_inf  = (&op_b.f.exp) & ~(|op_b.f.frac);
    b_zero = ~(|op_b.f.exp);
    sign_x = op_a.f.sign ^ op_b.f.sign;

    is_special   = 1'b1;
    special.bits = {sign_x, 31'd0};
    if (a_nan | b_nan) begin
      special.bits = mac_pkg::QNAN_BITS;
    end else if ((a_inf & b_zero) | (b_inf & a_zero)) begin
      special.bits = mac_pkg::QNAN_BITS;
    end else if (a_inf | b_inf) begin
      special.bits = {sign_x, 8'hff, 23'd0};
    end else if (!(a_zero | b_zero)) begin
      is_special = 1'b0;
    end
  end

  // Shift left once when the product's top bit is clear
  always_comb begin
    unrounded.sign   = prod_sign;
    unrounded.sticky = sticky;
    if (mant[23]) begin
      unrounded.exp       = prod_exp;
      unrounded.mant      = mant;
      unrounded.guard     = guard;
      unrounded.round_bit = round_bit;
    end else begin
      unrounded.exp       = prod_exp - 10'sd1;
      unrounded.mant      = {mant[22:0], guard};
      unrounded.guard     = round_bit;
      unrounded.round_bit = 1'b0;
    end
  end

  assign finish = (state == M_IDLE && start && is_special) || state == M_NORM;

  always_ff @(posedge aclk) begin
    if (!rstn) begin
      state <= M_IDLE;
      done  <= 1'b0;
    end else begin
      done <= finish;
      case (state)
        M_IDLE: if (start && !is_special) state <= M_TAKE;
        M_TAKE: state <= M_NORM;
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state == M_IDLE && start) begin
      prod_sign <= sign_x;
      prod_exp  <= 10'(int'(op_a.f.exp) + int'(op_b.f.exp) - 2 * mac_pkg::EXP_BIAS + 1);
      product   <= {1'b1, op_a.f.frac} * {1'b1, op_b.f.frac};
    end
    if (state == M_TAKE) begin
      mant      <= product[47:24];
      guard     <= product[23];
      round_bit <= product[22];
      sticky    <= |product[21:0];
    end
    if (finish) ab <= packed_word;
  end

  // Latency is 1 cycle for special operands and 3 otherwise
  done_after_start: assert property (@(posedge aclk) disable iff (!rstn)
    done |-> ($past(start) || $past(start, 3)));

endmodule

/* design/fp_round_pack.sv */
/* Combinational round-to-nearest-even and packing of a normalised value into a float word.
   Also applies overflow to infinity, flush to zero and the special-case bypass */
module fp_round_pack (
  input  mac_pkg::unrounded_t value,
  input  logic                is_special,
  input  mac_pkg::fp32_u      special,
  output mac_pkg::fp32_u      packed_word
);

  logic                       round_up;
  logic [mac_pkg::MANT_W:0]   mant_inc;
  logic [mac_pkg::MANT_W-1:0] mant_r;
  logic signed [9:0]          exp_r;

  always_comb begin
    round_up = value.guard & (value.round_bit | value.sticky | value.mant[0]);
    mant_inc = {1'b0, value.mant} + {{mac_pkg::MANT_W{1'b0}}, round_up};
    exp_r    = value.exp;
    mant_r   = mant_inc[mac_pkg::MANT_W-1:0];
    // Carry out of the mantissa bumps the exponent
    if (mant_inc[mac_pkg::MANT_W]) begin
      mant_r = mant_inc[mac_pkg::MANT_W:1];
      exp_r  = value.exp + 10'sd1;
    end

    if (is_special) begin
      packed_word = special;
    end else if (exp_r > mac_pkg::EXP_MAX) begin
      packed_word.bits = {value.sign, 8'(mac_pkg::EXP_SPECIAL + mac_pkg::EXP_BIAS), 23'd0};
    end else if (exp_r < mac_pkg::EXP_MIN || !mant_r[mac_pkg::MANT_W-1]) begin
      packed_word.bits = {value.sign, 31'd0};
    end else begin
      packed_word.bits = {value.sign, 8'(exp_r + mac_pkg::EXP_BIAS),
                          mant_r[mac_pkg::FRAC_W-1:0]};
    end
  end

endmodule

/* design/mac_pkg.sv */
/* Shared format constants and types for the single-precision multiply-accumulate unit.
   Every design file and the testbench refer to these by scoped name */
package mac_pkg;

  localparam int EXP_BIAS    = 127;
  localparam int EXP_MAX     = 127;
  localparam int EXP_MIN     = -126;
  localparam int EXP_SPECIAL = 128;
  localparam int FRAC_W      = 23;
  localparam int MANT_W      = 24;

  // Sign set, exponent all ones, top fraction bit set
  localparam logic [31:0] QNAN_BITS = 32'hffc00000;

  typedef struct packed {
    logic              sign;
    logic [7:0]        exp;
    logic [FRAC_W-1:0] frac;
  } fp32_fields_t;

  // One word, read either raw or as fields
  typedef union packed {
    logic [31:0]  bits;
    fp32_fields_t f;
  } fp32_u;

  // Normalised value waiting for rounding, exponent unbiased
  typedef struct packed {
    logic              sign;
    logic signed [9:0] exp;
    logic [MANT_W-1:0] mant;
    logic              guard;
    logic              round_bit;
    logic              sticky;
  } unrounded_t;

endpackage
